//--- vlog.f
common/rename_pkg.sv
rtl/checkpoint_ram.sv
rename/rename_map.sv
rename/free_list.sv
rename/checkpoint_alloc.sv
rename/rename_top.sv
tests/tb_rename.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_rename
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= all tests passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run $(TOP) and look for the pass message"
	@echo "  clean  remove the Verilator build directory"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS PASS_MSG"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- tests/tb_rename.sv
`timescale 1ns/1ps

module tb_rename import rename_pkg::*; ();

   localparam int TEST_CYCLES = 300;                 // Rough length of all tests together
   localparam int MAX_CYCLES  = 2 * TEST_CYCLES;

   logic         clka;
   logic         rst_n;
   logic         req_valid;
   rename_req_t  req;
   logic         req_ready;
   logic         rsp_valid;
   rename_rsp_t  rsp;
   logic         free_valid;
   preg_t        free_preg;
   logic         resolve_valid;
   checkpt_ndx_t resolve_ckpt;
   logic         mispredict;

   // Reference model of the rename state
   preg_t [AREGS-1:0] m_map;
   logic [PREGS-1:0]  m_avail;
   logic [PREGS-1:0]  m_freed [NCHECK];              // Commits since each slot's take
   preg_t [AREGS-1:0] m_ck_map [NCHECK];
   logic [PREGS-1:0]  m_ck_avail [NCHECK];
   checkpt_ndx_t      m_head;
   checkpt_ndx_t      m_tail;
   int                m_count;

   logic        exp_valid;                           // A response is due in this cycle
   rename_rsp_t exp_rsp;
   rename_rsp_t seen [$];                            // Responses seen during the current test
   string       test_name;
   int          err_cnt = 0;
   int          chk_cnt = 0;
   int          cycles  = 0;

   rename_top UUT (
      .clka, .rst_n, .req_valid, .req, .req_ready, .rsp_valid, .rsp,
      .free_valid, .free_preg, .resolve_valid, .resolve_ckpt, .mispredict
   );

   initial begin
      clka = 1'b0;
      forever #10 clka = ~clka;
   end

   always @(posedge clka) begin
      cycles = cycles + 1;
      if (cycles >= MAX_CYCLES) begin
         $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
         $display("Checks: %0d, errors: %0d", chk_cnt, err_cnt);
         $display("tests failed");
         $finish;
      end
   end

   // ==========================================================
   // Compare tasks
   // ==========================================================

   task automatic check_bit(input string what, input logic exp, input logic act);
      chk_cnt++;
      if (act !== exp) begin
         err_cnt++;
         $display("Fail %s %s: expected %b, actual %b", test_name, what, exp, act);
      end
   endtask

   task automatic check_preg(input string what, input preg_t exp, input preg_t act);
      chk_cnt++;
      if (act !== exp) begin
         err_cnt++;
         $display("Fail %s %s: expected %0d, actual %0d", test_name, what, exp, act);
      end
   endtask

   task automatic check_rsp(input rename_rsp_t exp, input rename_rsp_t act);
      chk_cnt++;
      if (act !== exp) begin
         err_cnt++;
         $display("Fail %s rsp: expected src %0d %0d dst %0d old %0d ckpt %0d/%b",
                  test_name, exp.psrc1, exp.psrc2, exp.pdst, exp.old_pdst, exp.ckpt,
                  exp.has_ckpt);
         $display("     actual src %0d %0d dst %0d old %0d ckpt %0d/%b",
                  act.psrc1, act.psrc2, act.pdst, act.old_pdst, act.ckpt, act.has_ckpt);
      end
   endtask

   // ==========================================================
   // Model helpers
   // ==========================================================

   function automatic preg_t lowest_free(input logic [PREGS-1:0] av);
      for (int i = 0; i < PREGS; i++) begin
         if (av[i])
            return preg_t'(i);
      end
      return '0;
   endfunction

   // Returns a busy register that no architectural register maps to or -1 when there is none
   function automatic int find_spare(input int start);
      int   p;
      logic mapped;
      for (int n = 0; n < PREGS; n++) begin
         p = (start + n) % PREGS;
         mapped = 1'b0;
         for (int a = 0; a < AREGS; a++) begin
            if (m_map[a] == preg_t'(p))
               mapped = 1'b1;
         end
         if (!m_avail[p] && !mapped)
            return p;
      end
      return -1;
   endfunction

   function automatic rename_req_t mk_req(input logic dst_en, input logic br, input int dst,
                                          input int s1, input int s2);
      rename_req_t r;
      r.has_dst   = dst_en;
      r.is_branch = br;
      r.dst       = areg_t'(dst);
      r.src1      = areg_t'(s1);
      r.src2      = areg_t'(s2);
      return r;
   endfunction

   task automatic model_reset();
      for (int i = 0; i < AREGS; i++)
         m_map[i] = preg_t'(i);                      // Identity map
      for (int i = 0; i < PREGS; i++)
         m_avail[i] = (i >= AREGS);                  // Upper half starts out free
      for (int k = 0; k < NCHECK; k++)
         m_freed[k] = '0;
      m_head    = '0;
      m_tail    = '0;
      m_count   = 0;
      exp_valid = 1'b0;
   endtask

   // Drives one cycle at the falling edge, checks the outputs and advances the model at the edge
   task automatic step(input logic rv, input rename_req_t r, input logic fv, input preg_t fp,
                       input logic resv, input logic mp, input checkpt_ndx_t rc);
      logic             needs;
      logic             ready;
      logic             fire;
      preg_t            pd;
      rename_rsp_t      nrsp;
      logic [PREGS-1:0] av;
      @(negedge clka);
      req_valid     = rv;
      req           = r;
      free_valid    = fv;
      free_preg     = fp;
      resolve_valid = resv;
      mispredict    = mp;
      resolve_ckpt  = rc;
      #1;                                            // Ready logic settles on the new inputs
      check_bit("rsp_valid", exp_valid, rsp_valid);
      if (exp_valid && rsp_valid) begin
         check_rsp(exp_rsp, rsp);
         seen.push_back(rsp);
      end
      needs = r.has_dst && (r.dst != '0);
      ready = !(resv && mp) && !(needs && (m_avail == '0))
           && !(r.is_branch && (m_count == NCHECK));
      check_bit("req_ready", ready, req_ready);
      fire          = rv && ready;
      pd            = needs ? lowest_free(m_avail) : '0;
      nrsp.psrc1    = m_map[r.src1];                 // Map before this instruction's update
      nrsp.psrc2    = m_map[r.src2];
      nrsp.pdst     = pd;
      nrsp.old_pdst = needs ? m_map[r.dst] : '0;
      nrsp.ckpt     = m_tail;
      nrsp.has_ckpt = r.is_branch;
      @(posedge clka);
      exp_valid = fire;
      exp_rsp   = nrsp;
      av        = m_avail;
      if (resv && mp) begin
         av      = m_ck_avail[rc] | m_freed[rc];     // Snapshot plus commits since its take
         m_map   = m_ck_map[rc];
         m_tail  = rc;                               // Slot rc and younger are dropped
         m_count = int'(checkpt_ndx_t'(rc - m_head));
      end else if (fire && needs) begin
         av[pd]       = 1'b0;
         m_map[r.dst] = pd;
      end
      if (fv) begin
         av[fp] = 1'b1;
         for (int k = 0; k < NCHECK; k++)
            m_freed[k][fp] = 1'b1;
      end
      if (fire && r.is_branch) begin
         m_ck_map[m_tail]   = m_map;                 // State after the branch's own rename
         m_ck_avail[m_tail] = av;
         m_freed[m_tail]    = '0;
         m_tail             = m_tail + checkpt_ndx_t'(1);
         m_count++;
      end
      if (resv && !mp) begin
         m_head = m_head + checkpt_ndx_t'(1);       // Oldest slot retires
         m_count--;
      end
      m_avail = av;
   endtask

   task automatic rename_one(input rename_req_t r);
      step(1'b1, r, 1'b0, '0, 1'b0, 1'b0, '0);
   endtask

   task automatic idle();
      step(1'b0, '0, 1'b0, '0, 1'b0, 1'b0, '0);
   endtask

   task automatic commit(input preg_t p);
      step(1'b0, '0, 1'b1, p, 1'b0, 1'b0, '0);
   endtask

   task automatic resolve(input checkpt_ndx_t k, input logic mp);
      step(1'b0, '0, 1'b0, '0, 1'b1, mp, k);
   endtask

   // ==========================================================
   // Directed tests
   // ==========================================================

   task automatic after_reset();
      test_name = "after reset";
      seen.delete();
      rename_one(mk_req(1'b1, 1'b0, 1, 2, 3));
      rename_one(mk_req(1'b1, 1'b0, 2, 4, 5));
      rename_one(mk_req(1'b1, 1'b0, 3, 6, 7));
      idle();
      check_preg("identity psrc1", 5'd2, seen[0].psrc1);
      check_preg("identity psrc2", 5'd7, seen[2].psrc2);
      check_preg("identity old_pdst", 5'd1, seen[0].old_pdst);
      check_preg("first pdst", 5'd16, seen[0].pdst);
      check_preg("second pdst", 5'd17, seen[1].pdst);
      check_preg("third pdst", 5'd18, seen[2].pdst);
   endtask

   task automatic dependent_chain();
      test_name = "dependent chain";
      seen.delete();
      rename_one(mk_req(1'b1, 1'b0, 1, 2, 3));       // r1 moves to 19
      rename_one(mk_req(1'b1, 1'b0, 4, 1, 1));       // Reads 19 and moves r4 to 20
      rename_one(mk_req(1'b1, 1'b0, 1, 4, 0));       // Renames r1 again and displaces 19
      rename_one(mk_req(1'b1, 1'b0, 0, 1, 2));       // Writing r0 allocates nothing
      rename_one(mk_req(1'b1, 1'b0, 5, 0, 1));
      idle();
      check_preg("old r1 mapping", 5'd16, seen[0].old_pdst);
      check_preg("chained psrc1", 5'd19, seen[1].psrc1);
      check_preg("displaced old_pdst", 5'd19, seen[2].old_pdst);
      check_preg("chained r4", 5'd20, seen[2].psrc1);
      check_preg("r0 pdst", '0, seen[3].pdst);
      check_preg("r0 old_pdst", '0, seen[3].old_pdst);
      check_preg("r0 source", '0, seen[4].psrc1);
      check_preg("allocation after r0", 5'd22, seen[4].pdst);
   endtask

   task automatic free_list_exhaustion();
      rename_req_t r;
      int          sp;
      test_name = "free list exhaustion";
      seen.delete();
      r = mk_req(1'b1, 1'b0, 5, 5, 6);
      while (m_avail != '0)
         rename_one(r);
      sp = find_spare(0);
      step(1'b1, r, 1'b1, preg_t'(sp), 1'b0, 1'b0, '0);  // Stalls because the commit lands later
      rename_one(r);
      idle();
      check_preg("freed register reused", preg_t'(sp), seen[$].pdst);
      sp = find_spare(0);
      while (sp >= 0) begin                          // Refill the pool for the next tests
         commit(preg_t'(sp));
         sp = find_spare(0);
      end
   endtask

   task automatic mispredict_restore();
      checkpt_ndx_t      slot;
      preg_t             old6;
      preg_t [AREGS-1:0] map_at_br;
      logic [PREGS-1:0]  avail_at_br;
      test_name = "mispredict";
      seen.delete();
      slot = m_tail;
      old6 = m_map[6];
      rename_one(mk_req(1'b1, 1'b1, 6, 1, 2));       // Branch that also writes r6
      map_at_br   = m_map;
      avail_at_br = m_avail;
      rename_one(mk_req(1'b1, 1'b0, 1, 6, 3));       // Wrong path
      rename_one(mk_req(1'b1, 1'b0, 2, 1, 1));
      commit(old6);                                  // Register displaced by the branch
      step(1'b1, mk_req(1'b1, 1'b0, 3, 1, 2), 1'b0, '0, 1'b1, 1'b1, slot);
      rename_one(mk_req(1'b1, 1'b0, 7, 1, 2));
      idle();
      avail_at_br[old6] = 1'b1;
      check_preg("psrc1 after restore", map_at_br[1], seen[$].psrc1);
      check_preg("psrc2 after restore", map_at_br[2], seen[$].psrc2);
      check_preg("pdst after restore", lowest_free(avail_at_br), seen[$].pdst);
   endtask

   task automatic checkpoint_limit();
      rename_req_t br;
      test_name = "checkpoint limit";
      seen.delete();
      br = mk_req(1'b0, 1'b1, 0, 3, 4);
      repeat (NCHECK)
         rename_one(br);
      step(1'b1, br, 1'b0, '0, 1'b1, 1'b0, m_head);  // Fifth branch waits while the oldest resolves
      rename_one(br);
      idle();
      check_bit("five branches renamed", 1'b1, seen.size() == NCHECK + 1);
      check_bit("fifth branch slot", 1'b1, seen[NCHECK].has_ckpt);
      check_bit("retired slot reused", 1'b1, seen[NCHECK].ckpt == seen[0].ckpt);
      while (m_count > 0)
         resolve(m_head, 1'b0);
   endtask

   task automatic random_mix();
      rename_req_t  r;
      logic         rv;
      logic         fv;
      logic         resv;
      logic         mp;
      int           sp;
      checkpt_ndx_t rc;
      test_name = "random mix";
      seen.delete();
      for (int n = 0; n < 200; n++) begin
         r = mk_req(($urandom % 4) != 0, ($urandom % 4) == 0, int'($urandom % AREGS),
                    int'($urandom % AREGS), int'($urandom % AREGS));
         rv   = ($urandom % 4) != 0;
         sp   = find_spare(int'($urandom % PREGS));
         fv   = (sp >= 0) && (($urandom % 3) == 0);
         resv = (m_count > 0) && (($urandom % 6) == 0);
         mp   = resv && (($urandom % 3) == 0);
         // A mispredict may hit any live slot while a correct resolve names the oldest
         rc   = mp ? checkpt_ndx_t'(m_head + checkpt_ndx_t'($urandom % m_count)) : m_head;
         step(rv, r, fv, preg_t'(sp), resv, mp, rc);
      end
      idle();
   endtask

   // ==========================================================
   // Main sequence
   // ==========================================================

   initial begin
      void'($urandom(60569));
      rst_n         = 1'b0;
      req_valid     = 1'b0;
      req           = '0;
      free_valid    = 1'b0;
      free_preg     = '0;
      resolve_valid = 1'b0;
      resolve_ckpt  = '0;
      mispredict    = 1'b0;
      test_name     = "reset";
      model_reset();
      repeat (2) @(posedge clka);
      @(negedge clka);
      rst_n = 1'b1;
      after_reset();
      dependent_chain();
      free_list_exhaustion();
      mispredict_restore();
      checkpoint_limit();
      random_mix();
      $display("Checks: %0d, errors: %0d", chk_cnt, err_cnt);
      if (err_cnt == 0)
         $display("all tests passed");
      else
         $display("tests failed");
      $finish;
   end

endmodule

//--- rename/rename_top.sv
`timescale 1ns/1ps

// Register rename subsystem, one instruction per cycle
module rename_top import rename_pkg::*; (
   input  logic         clka,
   input  logic         rst_n,
   input  logic         req_valid,
   input  rename_req_t  req,
   output logic         req_ready,
   output logic         rsp_valid,
   output rename_rsp_t  rsp,
   input  logic         free_valid,    // Commit of an instruction with a destination
   input  preg_t        free_preg,
   input  logic         resolve_valid, // Branch resolution
   input  checkpt_ndx_t resolve_ckpt,
   input  logic         mispredict
);

   logic             alloc_req;
   preg_t            alloc_preg;
   logic             empty;
   logic             take;
   checkpt_ndx_t     tail;
   logic             full;
   checkpoint_t      snapshot;       // Map half from the map table
   logic [PREGS-1:0] snap_avail;     // Avail half from the free list
   checkpoint_t      ram_din;
   checkpoint_t      ram_dout;       // Slot named by resolve_ckpt
   restore_t         restore;

   // Merge both halves of the snapshot
   assign ram_din.map   = snapshot.map;
   assign ram_din.avail = snap_avail;

   // ==========================================================
   // Blocks
   // ==========================================================

   rename_map u_map (
      .rst_n, .clka, .req_valid, .req, .req_ready, .rsp_valid, .rsp,
      .resolve_valid, .mispredict, .resolve_ckpt,
      .alloc_preg, .empty, .alloc_req, .tail, .full, .take,
      .snapshot, .ckpt_map(ram_dout), .restore
   );

   free_list u_free (
      .rst_n, .clka, .alloc_req, .alloc_preg, .empty, .free_valid, .free_preg,
      .take, .take_ndx(tail), .restore, .ckpt_avail(ram_dout.avail), .snap_avail
   );

   checkpoint_alloc u_ckpt (
      .rst_n, .clka, .take, .resolve_valid, .mispredict, .resolve_ckpt, .tail, .full
   );

   checkpoint_ram u_ram (
      .rst_n, .clka, .ena(take), .wea(take), .addra(tail), .dina(ram_din), .douta(),
      .addrb(resolve_ckpt), .doutb(ram_dout)
   );

   // A snapshot write never lands on the slot a resolve is working on
   a_ram_hazard : assert property (
      @(posedge clka) disable iff (!rst_n)
      take |-> !(resolve_valid && (resolve_ckpt == tail))
   ) else $error("rename_top: checkpoint write collides with resolve of slot %0d", tail);

endmodule

//--- rename/checkpoint_alloc.sv
`timescale 1ns/1ps

// In-order ring of checkpoint slots.
// Branches take slots at the tail, correct resolves retire them at the
// head, a mispredict cuts the ring back to the mispredicted slot.
module checkpoint_alloc import rename_pkg::*; (
   input  logic         rst_n,
   input  logic         clka,
   input  logic         take,
   input  logic         resolve_valid,
   input  logic         mispredict,
   input  checkpt_ndx_t resolve_ckpt,
   output checkpt_ndx_t tail,
   output logic         full
);

   checkpt_ndx_t     head_q;            // Oldest live slot
   checkpt_ndx_t     tail_q;            // Next slot to hand out
   logic [CNT_W-1:0] count_q;           // Live slots, 0 to NCHECK
   logic             correct;

   assign correct = resolve_valid && !mispredict;
   assign tail    = tail_q;
   assign full    = (count_q == CNT_W'(NCHECK));

   // ==========================================================
   // Ring pointers
   // ==========================================================

   always_ff @(posedge clka) begin
      if (!rst_n) begin
         head_q  <= '0;
         tail_q  <= '0;
         count_q <= '0;
      end else if (resolve_valid && mispredict) begin
         // The mispredicted slot and everything younger are dropped
         tail_q  <= resolve_ckpt;
         count_q <= CNT_W'(checkpt_ndx_t'(resolve_ckpt - head_q));
      end else begin
         if (take)
            tail_q <= tail_q + checkpt_ndx_t'(1);
         if (correct)
            head_q <= head_q + checkpt_ndx_t'(1);
         case ({take, correct})
            2'b10:   count_q <= count_q + CNT_W'(1);
            2'b01:   count_q <= count_q - CNT_W'(1);
            default: count_q <= count_q;   // Take and retire in one cycle cancel out
         endcase
      end
   end

   // ==========================================================
   // Checks
   // ==========================================================

   // Correct resolves are expected oldest first
   a_resolve_head : assert property (
      @(posedge clka) disable iff (!rst_n)
      correct |-> (resolve_ckpt == head_q) && (count_q != '0)
   ) else $error("checkpoint_alloc: correct resolve of slot %0d, head is %0d",
                 resolve_ckpt, head_q);

   // The map table must hold branches back while every slot is live
   a_take_full : assert property (
      @(posedge clka) disable iff (!rst_n)
      take |-> !full
   ) else $error("checkpoint_alloc: checkpoint taken while all slots are live");

endmodule

//--- rename/free_list.sv
`timescale 1ns/1ps

// Physical register free list.
// One availability bit per register, lowest-free allocation, freeing on
// commit, and a freed-since mask per checkpoint slot for the restore.
module free_list import rename_pkg::*; (
   input  logic         rst_n,
   input  logic         clka,
   input  logic         alloc_req,
   output preg_t        alloc_preg,
   output logic         empty,
   input  logic         free_valid,    // Commit frees the displaced register
   input  preg_t        free_preg,
   input  logic         take,          // Branch snapshot in this cycle
   input  checkpt_ndx_t take_ndx,
   input  restore_t     restore,
   input  logic [PREGS-1:0] ckpt_avail,   // Avail half of the restored slot
   output logic [PREGS-1:0] snap_avail    // Avail half of a new snapshot
);

   logic [PREGS-1:0] avail_q;
   logic [PREGS-1:0] avail_nxt;
   logic [PREGS-1:0] freed_q [NCHECK];   // Registers committed since each slot's take

   // ==========================================================
   // Lowest-free priority encoder
   // ==========================================================

   always_comb begin
      alloc_preg = '0;
      for (int i = PREGS - 1; i >= 0; i--) begin
         if (avail_q[i])
            alloc_preg = preg_t'(i);    // Last hit wins, so the lowest set bit
      end
   end

   assign empty = ~|avail_q;

   // Allocation sees only the current vector, a same-edge commit is not visible
   always_comb begin
      avail_nxt = avail_q;
      if (alloc_req)
         avail_nxt[alloc_preg] = 1'b0;
      if (free_valid)
         avail_nxt[free_preg] = 1'b1;
   end

   // Includes a same-cycle commit, so the taken slot's mask can start empty
   assign snap_avail = avail_nxt;

   // ==========================================================
   // State update
   // ==========================================================

   always_ff @(posedge clka) begin
      if (!rst_n) begin
         avail_q <= AVAIL_RESET;
      end else if (restore.valid) begin
         // Snapshot avail plus everything committed since that snapshot
         avail_q <= ckpt_avail | freed_q[restore.ndx] | (PREGS'(free_valid) << free_preg);
      end else begin
         avail_q <= avail_nxt;
      end
   end

   always_ff @(posedge clka) begin
      for (int k = 0; k < NCHECK; k++) begin
         if (!rst_n)
            freed_q[k] <= '0;
         else if (take && (take_ndx == checkpt_ndx_t'(k)))
            freed_q[k] <= '0;           // Fresh slot, its snapshot already has the commit
         else if (free_valid)
            freed_q[k][free_preg] <= 1'b1;
      end
   end

   // A commit may only free a register that some instruction still holds
   a_free_busy : assert property (
      @(posedge clka) disable iff (!rst_n)
      free_valid |-> !avail_q[free_preg]
   ) else $error("free_list: commit frees register %0d which is already free", free_preg);

endmodule

//--- rename/rename_map.sv
`timescale 1ns/1ps

// Map table of the rename stage.
// Looks up both sources, allocates the destination, takes branch
// snapshots and rolls the map back on a mispredict.
module rename_map import rename_pkg::*; (
   input  logic         rst_n,
   input  logic         clka,
   input  logic         req_valid,
   input  rename_req_t  req,
   output logic         req_ready,
   output logic         rsp_valid,
   output rename_rsp_t  rsp,
   input  logic         resolve_valid,
   input  logic         mispredict,
   input  checkpt_ndx_t resolve_ckpt,
   input  preg_t        alloc_preg,    // Lowest free register from the free list
   input  logic         empty,
   output logic         alloc_req,
   input  checkpt_ndx_t tail,          // Slot the next branch will use
   input  logic         full,
   output logic         take,
   output checkpoint_t  snapshot,      // Map half only, the top adds avail
   input  checkpoint_t  ckpt_map,      // Slot addressed by resolve_ckpt
   output restore_t     restore
);

   preg_t [AREGS-1:0] map_q;           // Current speculative map
   preg_t [AREGS-1:0] map_nxt;         // Map after this cycle's rename
   logic              needs_dst;
   logic              fire;

   // ==========================================================
   // Acceptance
   // ==========================================================

   // Architectural register 0 is hardwired to physical 0 and never renamed
   assign needs_dst = req.has_dst && (req.dst != '0);

   // Stall on a mispredict cycle, on no free register, or on no free slot
   assign req_ready = !(resolve_valid && mispredict)
                   && !(needs_dst && empty)
                   && !(req.is_branch && full);

   assign fire      = req_valid && req_ready;
   assign alloc_req = fire && needs_dst;
   assign take      = fire && req.is_branch;   // Also drives the RAM write enables

   assign restore.valid = resolve_valid && mispredict;
   assign restore.ndx   = resolve_ckpt;

   // ==========================================================
   // Map update
   // ==========================================================

   always_comb begin
      map_nxt = map_q;
      if (alloc_req)
         map_nxt[req.dst] = alloc_preg;  // A branch snapshot sees its own destination
   end

   // Snapshot holds the map after the branch's own rename
   assign snapshot.map   = map_nxt;
   assign snapshot.avail = '0;            // Filled in from the free list at the top

   always_ff @(posedge clka) begin
      if (!rst_n) begin
         for (int i = 0; i < AREGS; i++)
            map_q[i] <= preg_t'(i);       // Identity map out of reset
      end else if (restore.valid) begin
         map_q <= ckpt_map.map;           // Roll back to the branch snapshot
      end else begin
         map_q <= map_nxt;
      end
   end

   // ==========================================================
   // Response register
   // ==========================================================

   always_ff @(posedge clka) begin
      if (!rst_n)
         rsp_valid <= 1'b0;
      else
         rsp_valid <= fire;               // Exactly one cycle per accepted request
   end

   // Sources read the map before this instruction's own update
   always_ff @(posedge clka) begin
      rsp.psrc1    <= map_q[req.src1];
      rsp.psrc2    <= map_q[req.src2];
      rsp.pdst     <= needs_dst ? alloc_preg : '0;
      rsp.old_pdst <= needs_dst ? map_q[req.dst] : '0;
      rsp.ckpt     <= tail;
      rsp.has_ckpt <= req.is_branch;
   end

endmodule

//--- rtl/checkpoint_ram.sv
`timescale 1ns/1ps

// Small distributed RAM holding one rename snapshot per checkpoint slot
// Port A writes at the clock edge and both ports read without a clock
module checkpoint_ram import rename_pkg::*; (
   input  logic         rst_n,
   input  logic         clka,
   input  logic         ena,      // Port A enable
   input  logic         wea,      // Port A write strobe
   input  checkpt_ndx_t addra,    // Slot being snapshotted, the ring tail
   input  checkpoint_t  dina,
   output checkpoint_t  douta,
   input  checkpt_ndx_t addrb,    // Slot being restored on a mispredict
   output checkpoint_t  doutb
);

   // ==========================================================
   // Storage
   // ==========================================================

   // Only NCHECK entries, so this maps onto LUT RAM rather than a block RAM
   checkpoint_t mem [NCHECK];

   // Each take writes the snapshot of its branch into the tail slot
   always_ff @(posedge clka) begin
      if (ena && wea)
         mem[addra] <= dina;      // Snapshot lands at the edge of the take
   end

   // ==========================================================
   // Read ports
   // ==========================================================

   // A write in this cycle shows on the read ports only after the edge
   assign douta = mem[addra];
   assign doutb = mem[addrb];     // Feeds the map restore and the avail restore

   // ==========================================================
   // Checks
   // ==========================================================

   // The snapshot is assembled from the map table and the free list,
   // an unknown bit here would silently corrupt a later restore
   a_write_known : assert property (
      @(posedge clka) disable iff (!rst_n)
      (ena && wea) |-> !$isunknown({addra, dina})
   ) else $error("checkpoint_ram: write with unknown address or data");

endmodule

//--- common/rename_pkg.sv
package rename_pkg;

   // ==========================================================
   // Sizes of the rename machine
   // ==========================================================

   localparam int AREGS  = 16;                 // Architectural registers seen by software
   localparam int PREGS  = 32;                 // Physical registers behind them
   localparam int NCHECK = 4;                  // Branch checkpoint slots, power of two

   localparam int AREG_W = $clog2(AREGS);
   localparam int PREG_W = $clog2(PREGS);
   localparam int CKPT_W = $clog2(NCHECK);
   localparam int CNT_W  = $clog2(NCHECK + 1); // Live count has to reach NCHECK itself

   // Out of reset the low AREGS physical registers hold the identity map,
   // so only the upper ones start out free
   localparam logic [PREGS-1:0] AVAIL_RESET = {{(PREGS - AREGS){1'b1}}, {AREGS{1'b0}}};

   // ==========================================================
   // Register numbers
   // ==========================================================

   typedef logic [AREG_W-1:0] areg_t;         // Architectural register number
   typedef logic [PREG_W-1:0] preg_t;         // Physical register number
   typedef logic [CKPT_W-1:0] checkpt_ndx_t;  // Checkpoint slot index

   // One snapshot of the rename state
   // The map is AREGS x PREG_W bits and avail has one bit per physical register
   typedef struct packed {
      preg_t [AREGS-1:0] map;                 // Architectural to physical map
      logic  [PREGS-1:0] avail;               // Set where a physical register is free
   } checkpoint_t;

   // ==========================================================
   // Rename request and response
   // ==========================================================

   typedef struct packed {
      logic  has_dst;                         // Instruction writes a register
      logic  is_branch;                       // Instruction needs a checkpoint
      areg_t dst;
      areg_t src1;
      areg_t src2;
   } rename_req_t;

   typedef struct packed {
      preg_t        psrc1;                    // Physical source operands
      preg_t        psrc2;
      preg_t        pdst;                     // Newly allocated destination, 0 if none
      preg_t        old_pdst;                 // Mapping that pdst displaced, freed on commit
      checkpt_ndx_t ckpt;                     // Slot holding this branch's snapshot
      logic         has_ckpt;
   } rename_rsp_t;

   // Mispredict restore as broadcast by the map table
   typedef struct packed {
      logic         valid;
      checkpt_ndx_t ndx;                      // Slot to roll back to
   } restore_t;

endpackage
